// File: verilog/bpred_pkg.sv
package bpred_pkg;

	// Packet handed out by fetch and held in the branch queue
	typedef struct packed {
		logic [31:0] pc;
		logic        pred_taken;
		logic [31:0] pred_next;  // Predicted next fetch address
	} fetch_pkt_t;

	// Execution outcome, arrives in program order
	typedef struct packed {
		logic        is_branch;
		logic        taken;
		logic [31:0] target;
	} resolve_t;

	// One training write into the predictor tables
	typedef struct packed {
		logic [31:0] pc;
		logic        taken;
		logic [31:0] target;
	} update_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;  // Corrected fetch address
	} redirect_t;

	// Bimodal counter states, ordered so that +1 moves toward taken
	localparam logic [1:0] CNT_STRONG_NT = 2'b00;
	localparam logic [1:0] CNT_WEAK_NT   = 2'b01;
	localparam logic [1:0] CNT_WEAK_T    = 2'b10;
	localparam logic [1:0] CNT_STRONG_T  = 2'b11;

endpackage

// File: verilog/branch_predictor.sv
module branch_predictor #(
	parameter int INDEX_BITS = 7
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic [31:0]         lookup_pc_i,
	output logic                pred_taken_o,
	output logic [31:0]         pred_next_o,
	input  logic                update_valid_i,
	input  bpred_pkg::update_t  update_i
);

	localparam int ENTRIES  = 1 << INDEX_BITS;
	localparam int TAG_BITS = 30 - INDEX_BITS;

	// Direct-mapped table state
	logic [ENTRIES-1:0]  valid_q;
	logic [1:0]          cnt_q    [ENTRIES];
	logic [TAG_BITS-1:0] tag_q    [ENTRIES];
	logic [31:0]         target_q [ENTRIES];

	logic [INDEX_BITS-1:0] lk_idx;
	logic [TAG_BITS-1:0]   lk_tag;
	logic                  lk_hit;

	logic [INDEX_BITS-1:0] up_idx;
	logic [TAG_BITS-1:0]   up_tag;
	logic                  up_hit;
	logic [1:0]            up_cnt;

	// Saturating step toward the resolved direction
	function automatic logic [1:0] step_cnt(input logic [1:0] cnt, input logic taken);
		logic [1:0] nxt;
		nxt = cnt;
		if (taken) begin
			if (cnt != bpred_pkg::CNT_STRONG_T)
				nxt = cnt + 2'd1;
		end else begin
			if (cnt != bpred_pkg::CNT_STRONG_NT)
				nxt = cnt - 2'd1;
		end
		return nxt;
	endfunction

	// Lookup path, purely combinational
	assign lk_idx = lookup_pc_i[INDEX_BITS+1:2];
	assign lk_tag = lookup_pc_i[31:INDEX_BITS+2];
	assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

	always_comb begin
		pred_taken_o = lk_hit && cnt_q[lk_idx][1];  // Upper bit means taken
		if (pred_taken_o)
			pred_next_o = target_q[lk_idx];
		else
			pred_next_o = lookup_pc_i + 32'd4;
	end

	// Training path
	assign up_idx = update_i.pc[INDEX_BITS+1:2];
	assign up_tag = update_i.pc[31:INDEX_BITS+2];
	assign up_hit = valid_q[up_idx] && (tag_q[up_idx] == up_tag);

	always_comb begin
		if (up_hit)
			up_cnt = step_cnt(cnt_q[up_idx], update_i.taken);
		else
			up_cnt = bpred_pkg::CNT_STRONG_NT;  // New owner starts cold
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			valid_q <= '0;
			cnt_q   <= '{default: bpred_pkg::CNT_STRONG_NT};
		end else if (update_valid_i) begin
			valid_q[up_idx] <= 1'b1;
			cnt_q[up_idx]   <= up_cnt;
		end
	end

	always_ff @(posedge clk_i) begin
		if (update_valid_i) begin
			if (!up_hit)
				tag_q[up_idx] <= up_tag;
			// Target follows every taken branch, hit or miss
			if (update_i.taken)
				target_q[up_idx] <= update_i.target;
		end
	end

endmodule

// File: verilog/fetch_unit.sv
module fetch_unit #(
	parameter logic [31:0] RESET_PC = 32'h1000
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   push_ready_i,
	input  logic                   fetch_ready_i,
	output logic                   fetch_valid_o,
	output bpred_pkg::fetch_pkt_t  fetch_o,
	output logic [31:0]            lookup_pc_o,
	input  logic                   pred_taken_i,
	input  logic [31:0]            pred_next_i,
	input  bpred_pkg::redirect_t   redirect_i
);

	logic [31:0]           pc_q;
	logic                  active_q;  // Set one edge after reset
	logic                  held_q;    // Packet was offered but not taken
	bpred_pkg::fetch_pkt_t pkt_q;
	bpred_pkg::fetch_pkt_t live_pkt;
	logic                  xfer;

	assign lookup_pc_o = pc_q;

	always_comb begin
		live_pkt.pc         = pc_q;
		live_pkt.pred_taken = pred_taken_i;
		live_pkt.pred_next  = pred_next_i;
	end

	// A stalled packet keeps its first prediction even if the table trains meanwhile
	assign fetch_o = held_q ? pkt_q : live_pkt;

	// No issue into a full queue or on the wrong path
	assign fetch_valid_o = active_q && push_ready_i && !redirect_i.valid;
	assign xfer          = fetch_valid_o && fetch_ready_i;

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			active_q <= 1'b0;
			held_q   <= 1'b0;
			pc_q     <= RESET_PC;
		end else begin
			active_q <= 1'b1;
			held_q   <= fetch_valid_o && !fetch_ready_i;
			if (redirect_i.valid)
				pc_q <= redirect_i.pc;
			else if (xfer)
				pc_q <= fetch_o.pred_next;
		end
	end

	always_ff @(posedge clk_i) begin
		if (fetch_valid_o && !fetch_ready_i)
			pkt_q <= fetch_o;
	end

endmodule

// File: verilog/branch_queue.sv
module branch_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   push_valid_i,
	input  bpred_pkg::fetch_pkt_t  push_i,
	output logic                   push_ready_o,
	output logic                   pop_valid_o,
	output bpred_pkg::fetch_pkt_t  pop_o,
	input  logic                   pop_ready_i,
	input  logic                   flush_i
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	bpred_pkg::fetch_pkt_t mem_q [QUEUE_DEPTH];
	logic [PTR_W-1:0]      wr_ptr_q;
	logic [PTR_W-1:0]      rd_ptr_q;
	logic [CNT_W-1:0]      count_q;
	logic                  push;
	logic                  pop;

	// Wraps at the depth, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign push_ready_o = (count_q != CNT_W'(QUEUE_DEPTH));
	assign pop_valid_o  = (count_q != '0);
	assign pop_o        = mem_q[rd_ptr_q];
	assign push         = push_valid_i && push_ready_o;
	assign pop          = pop_valid_o && pop_ready_i;

	always_ff @(posedge clk_i) begin
		if (!rst_i || flush_i) begin  // Flush wins over push
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (pop)
				rd_ptr_q <= next_ptr(rd_ptr_q);
			count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
		end
	end

	always_ff @(posedge clk_i) begin
		if (push && !flush_i)
			mem_q[wr_ptr_q] <= push_i;
	end

endmodule

// File: verilog/branch_resolver.sv
module branch_resolver (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   res_valid_i,
	input  bpred_pkg::resolve_t    res_i,
	output logic                   res_ready_o,
	input  logic                   head_valid_i,
	input  bpred_pkg::fetch_pkt_t  head_i,
	output logic                   pop_o,
	output logic                   update_valid_o,
	output bpred_pkg::update_t     update_o,
	output bpred_pkg::redirect_t   redirect_o,
	output logic [15:0]            mispredicts_o
);

	logic        xfer;
	logic [31:0] correct_next;
	logic        mispredict;
	logic [15:0] mispredicts_q;

	// Outcome pairs with the oldest in-flight fetch
	assign res_ready_o = head_valid_i;
	assign xfer        = res_valid_i && head_valid_i;
	assign pop_o       = xfer;

	always_comb begin
		if (res_i.is_branch && res_i.taken)
			correct_next = res_i.target;
		else
			correct_next = head_i.pc + 32'd4;  // Fall through
	end

	assign mispredict = xfer && (correct_next != head_i.pred_next);

	always_comb begin
		redirect_o.valid = mispredict;
		redirect_o.pc    = correct_next;
	end

	// Non-branches leave the tables alone
	assign update_valid_o = xfer && res_i.is_branch;

	always_comb begin
		update_o.pc     = head_i.pc;
		update_o.taken  = res_i.taken;
		update_o.target = res_i.target;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i)
			mispredicts_q <= '0;
		else if (mispredict)
			mispredicts_q <= mispredicts_q + 16'd1;  // Wraps
	end

	assign mispredicts_o = mispredicts_q;

endmodule

// File: verilog/bpred_top.sv
module bpred_top #(
	parameter int          INDEX_BITS  = 7,
	parameter int          QUEUE_DEPTH = 4,
	parameter logic [31:0] RESET_PC    = 32'h1000
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	output logic                   fetch_valid_o,
	input  logic                   fetch_ready_i,
	output bpred_pkg::fetch_pkt_t  fetch_o,
	input  logic                   res_valid_i,
	input  bpred_pkg::resolve_t    res_i,
	output logic                   res_ready_o,
	output bpred_pkg::redirect_t   redirect_o,
	output logic [15:0]            mispredicts_o
);

	logic [31:0]           lookup_pc;
	logic                  pred_taken;
	logic [31:0]           pred_next;
	logic                  push_ready;
	logic                  head_valid;
	bpred_pkg::fetch_pkt_t head;
	logic                  pop;
	logic                  update_valid;
	bpred_pkg::update_t    update;

	branch_predictor #(.INDEX_BITS(INDEX_BITS)) u_predictor (
		.clk_i(clk_i), .rst_i(rst_i),
		.lookup_pc_i(lookup_pc), .pred_taken_o(pred_taken), .pred_next_o(pred_next),
		.update_valid_i(update_valid), .update_i(update)
	);

	fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
		.clk_i(clk_i), .rst_i(rst_i),
		.push_ready_i(push_ready), .fetch_ready_i(fetch_ready_i),
		.fetch_valid_o(fetch_valid_o), .fetch_o(fetch_o), .lookup_pc_o(lookup_pc),
		.pred_taken_i(pred_taken), .pred_next_i(pred_next), .redirect_i(redirect_o)
	);

	// Every fetch transfer is also a push, so the queue mirrors what left the unit
	branch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.clk_i(clk_i), .rst_i(rst_i),
		.push_valid_i(fetch_valid_o && fetch_ready_i), .push_i(fetch_o),
		.push_ready_o(push_ready), .pop_valid_o(head_valid), .pop_o(head),
		.pop_ready_i(pop), .flush_i(redirect_o.valid)
	);

	branch_resolver u_resolver (
		.clk_i(clk_i), .rst_i(rst_i),
		.res_valid_i(res_valid_i), .res_i(res_i), .res_ready_o(res_ready_o),
		.head_valid_i(head_valid), .head_i(head), .pop_o(pop),
		.update_valid_o(update_valid), .update_o(update),
		.redirect_o(redirect_o), .mispredicts_o(mispredicts_o)
	);

endmodule

// File: test/bpred_assertions.sv
module bpred_assertions (
	input logic                  clk_i,
	input logic                  rst_i,
	input logic                  fetch_valid_o,
	input logic                  fetch_ready_i,
	input bpred_pkg::fetch_pkt_t fetch_o,
	input logic                  res_valid_i,
	input logic                  res_ready_o,
	input bpred_pkg::redirect_t  redirect_o
);

	// A stalled packet waits unchanged unless the path is redirected
	assert property (@(posedge clk_i) disable iff (!rst_i)
		(fetch_valid_o && !fetch_ready_i) |=>
		(redirect_o.valid || (fetch_valid_o && fetch_o == $past(fetch_o))))
		else $error("fetch packet changed under back-pressure");

	assert property (@(posedge clk_i) disable iff (!rst_i)
		redirect_o.valid |-> (res_valid_i && res_ready_o))
		else $error("redirect without a resolution transfer");

	// Checked from the second reset cycle, once the queue count is cleared
	assert property (@(posedge clk_i)
		(!rst_i && $past(!rst_i)) |-> !res_ready_o)
		else $error("res_ready_o high during reset");

endmodule

bind bpred_top bpred_assertions u_assertions (.*);

// File: test/bpred_tb.sv
module bpred_tb;

	logic clk_i, rst_i, fetch_ready_i, res_valid_i, fetch_valid_o, res_ready_o;
	bpred_pkg::resolve_t   res_i;
	bpred_pkg::fetch_pkt_t fetch_o;
	bpred_pkg::redirect_t  redirect_o;
	logic [15:0]           mispredicts_o;

	bpred_top dut (.*);

	// Reference model state
	logic        m_valid [128];
	logic [22:0] m_tag   [128];
	logic [1:0]  m_cnt   [128];
	logic [31:0] m_tgt   [128];
	logic [31:0] q_pc [$];
	logic [31:0] q_next [$];
	logic [31:0] m_pc, held_next, seed;
	logic        m_held, held_taken, alias_seen;
	int          m_miss, mode, cycles, res_hits;

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycles++;
		if (cycles >= 4000) begin
			$display("Timeout: the run went past 4000 cycles");
			$display("Verification failed");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] xorshift();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	task automatic check(input logic [31:0] act, input logic [31:0] exp, input string msg);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, msg, act, exp);
			$display("Verification failed");
			$fatal(1, "check failed");
		end
	endtask

	// Returns {taken, next} with the index from PC bits 8:2
	function automatic logic [32:0] predict(input logic [31:0] pc);
		if (m_valid[pc[8:2]] && m_tag[pc[8:2]] == pc[31:9] && m_cnt[pc[8:2]][1])
			return {1'b1, m_tgt[pc[8:2]]};
		return {1'b0, pc + 32'd4};
	endfunction

	task automatic train(input logic [31:0] pc, input logic taken, input logic [31:0] tgt);
		logic [6:0] i;
		i = pc[8:2];
		if (m_valid[i] && m_tag[i] == pc[31:9]) begin
			if (taken && m_cnt[i] != 2'd3) m_cnt[i] = m_cnt[i] + 2'd1;
			else if (!taken && m_cnt[i] != 2'd0) m_cnt[i] = m_cnt[i] - 2'd1;
		end else begin
			m_valid[i] = 1'b1;
			m_tag[i] = pc[31:9];
			m_cnt[i] = 2'd0;  // Cold start on a miss
		end
		if (taken) m_tgt[i] = tgt;
	endtask

	// Outcome of each PC in the program of the current test
	function automatic bpred_pkg::resolve_t outcome(input logic [31:0] pc);
		logic [31:0] r;
		case (mode)
			1: return (pc == 32'h1010 || pc == 32'h1014) ? {1'b1, 1'b1, 32'h1000} : '0;
			2: begin
				if (pc == 32'h1010) return {1'b1, 1'b0, 32'h1000};
				return (pc == 32'h1014) ? {1'b1, 1'b1, 32'h1000} : '0;
			end
			3: begin
				if (pc == 32'h1010) return {1'b1, 1'b1, 32'h1210};
				return (pc == 32'h1210) ? {1'b1, 1'b1, 32'h1000} : '0;
			end
			4: begin
				r = xorshift();
				return {r[0] & r[1], r[2], 32'h1000 + {22'd0, r[15:8], 2'b00}};
			end
			default: return '0;
		endcase
	endfunction

	// Drive at the falling edge, check, then advance the model one cycle
	task automatic step(input logic fready, input logic rvalid);
		logic [32:0] pr;
		logic [31:0] exp_next, correct, head;
		logic        exp_taken, exp_fv, redir, rx;
		bpred_pkg::resolve_t r;
		@(negedge clk_i);
		rx = rvalid && q_pc.size() > 0;
		head = rx ? q_pc[0] : 32'd0;
		r = rx ? outcome(head) : '0;
		fetch_ready_i = fready;
		res_valid_i = rx;
		res_i = r;
		#1;
		correct = (r.is_branch && r.taken) ? r.target : head + 32'd4;
		redir = rx && correct != q_next[0];
		check(32'(res_ready_o), 32'(q_pc.size() > 0), "res_ready_o");
		check(32'(redirect_o.valid), 32'(redir), "redirect valid");
		if (redir) check(redirect_o.pc, correct, "redirect pc");
		check(32'(mispredicts_o), 32'(m_miss), "mispredicts_o");
		exp_fv = q_pc.size() < 4 && !redir;
		check(32'(fetch_valid_o), 32'(exp_fv), "fetch_valid_o");
		pr = predict(m_pc);
		exp_taken = m_held ? held_taken : pr[32];
		exp_next = m_held ? held_next : pr[31:0];
		if (exp_fv) begin
			check(fetch_o.pc, m_pc, "fetch pc");
			check(32'(fetch_o.pred_taken), 32'(exp_taken), "pred_taken");
			check(fetch_o.pred_next, exp_next, "pred_next");
			if (mode == 3 && alias_seen && (m_pc == 32'h1010 || m_pc == 32'h1210))
				check(32'(fetch_o.pred_taken), 32'd0, "aliased entry pred_taken");
		end
		if (redir) begin
			m_pc = correct;
			q_pc.delete();
			q_next.delete();
			m_held = 1'b0;
			m_miss++;
		end else begin
			if (rx) begin
				void'(q_pc.pop_front());
				void'(q_next.pop_front());
			end
			if (exp_fv && fready) begin
				q_pc.push_back(m_pc);
				q_next.push_back(exp_next);
				m_pc = exp_next;
				m_held = 1'b0;
			end else begin
				m_held = exp_fv;  // Stalled packet keeps its prediction
				held_taken = exp_taken;
				held_next = exp_next;
			end
		end
		if (rx && r.is_branch) train(head, r.taken, r.target);
		if (rx && mode == 3 && head == 32'h1210) alias_seen = 1'b1;
		if (rx && head == 32'h1010) res_hits++;
	endtask

	task automatic run_until_resolved(input int m, input int n);
		mode = m;
		res_hits = 0;
		while (res_hits < n) step(1'b1, 1'b1);
	endtask

	task automatic test_reset_and_stall();
		step(1'b0, 1'b0);
		check(fetch_o.pc, 32'h1000, "first fetch pc");
		repeat (5) step(1'b0, 1'b0);  // Fetch held back
		repeat (8) step(1'b1, 1'b0);  // Queue fills then fetch stops
		check(32'(fetch_valid_o), 32'd0, "fetch stops on full queue");
		repeat (4) step(1'b1, 1'b1);  // Branch at 1010 stays in flight
	endtask

	task automatic test_training();
		int base;
		base = m_miss;
		run_until_resolved(1, 6);
		step(1'b1, 1'b0);
		check(32'(mispredicts_o) - 32'(base), 32'd3, "training mispredicts");
		run_until_resolved(2, 6);
	endtask

	task automatic test_alias();
		alias_seen = 1'b0;
		run_until_resolved(1, 4);  // First owner trained to taken
		run_until_resolved(3, 8);
	endtask

	task automatic test_random();
		logic [31:0] r;
		mode = 4;
		repeat (1500) begin
			r = xorshift();
			step(r[3] | r[4], r[5] | r[6]);
		end
		step(1'b1, 1'b0);
		check(32'(mispredicts_o), 32'(m_miss), "final mispredicts_o");
	endtask

	initial begin
		seed = 32'd92065;
		cycles = 0;
		m_miss = 0;
		mode = 0;
		m_pc = 32'h1000;
		m_held = 1'b0;
		alias_seen = 1'b0;
		for (int i = 0; i < 128; i++) m_valid[i] = 1'b0;
		rst_i = 1'b0;
		fetch_ready_i = 1'b0;
		res_valid_i = 1'b0;
		res_i = '0;
		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		check(32'(fetch_valid_o), 32'd0, "fetch_valid_o in reset");
		check(32'(res_ready_o), 32'd0, "res_ready_o in reset");
		check(32'(redirect_o.valid), 32'd0, "redirect valid in reset");
		rst_i = 1'b1;
		test_reset_and_stall();
		test_training();
		test_alias();
		test_random();
		$display("Verification passed");
		$finish;
	end

endmodule

// File: bpred.f
verilog/bpred_pkg.sv
verilog/branch_predictor.sv
verilog/fetch_unit.sv
verilog/branch_queue.sv
verilog/branch_resolver.sv
verilog/bpred_top.sv
test/bpred_assertions.sv
test/bpred_tb.sv

// File: run_sim.sh
#!/bin/sh
# Exit status follows the testbench result
rm -rf obj_dir &&
verilator --binary --assert -j 0 --top-module bpred_tb -f bpred.f &&
./obj_dir/Vbpred_tb ||
exit 1
